// File: design/xr_pkg.sv
`default_nettype none

package xr_pkg;

  localparam int WIDTH     = 32;
  localparam int NUM_BANKS = 4;
  localparam int BANK_BITS = 2;
  localparam int NUM_ROWS  = 64;
  localparam int ROW_BITS  = 6;
  localparam int ADDR_BITS = BANK_BITS + ROW_BITS; // bank in the upper bits.

  typedef logic [WIDTH-1:0]     data_t;
  typedef logic [ADDR_BITS-1:0] addr_t;
  typedef logic [BANK_BITS-1:0] bank_t;
  typedef logic [ROW_BITS-1:0]  row_t;
  typedef logic [NUM_BANKS-1:0] bank_mask_t; // one bit per data bank.

  // port B owner: init sweep, idle/fetch of old words, or write-back.
  typedef enum logic [1:0] {
    ws_init,
    ws_idle,
    ws_update
  } write_state_t;

endpackage

`default_nettype wire

// File: design/xr_dual_port_ram.sv
`timescale 1ns/1ps
`default_nettype none

module xr_dual_port_ram (
  input  wire logic         clk,
  input  wire logic         a_en,
  input  wire xr_pkg::row_t a_row,
  output xr_pkg::data_t     a_dout,
  input  wire logic         b_en,
  input  wire logic         b_we,
  input  wire xr_pkg::row_t b_row,
  input  wire xr_pkg::data_t b_wdata,
  output xr_pkg::data_t     b_dout
);

  xr_pkg::data_t mem [xr_pkg::NUM_ROWS];

  always_ff @(posedge clk) begin
    if (a_en) begin
      a_dout <= mem[a_row]; // sees the word before a same-edge write.
    end
  end

  always_ff @(posedge clk) begin
    if (b_en) begin
      b_dout <= mem[b_row]; // read-first on port B as well.
      if (b_we) begin
        mem[b_row] <= b_wdata;
      end
    end
  end

endmodule

`default_nettype wire

// File: design/xr_bank_array.sv
`timescale 1ns/1ps
`default_nettype none

module xr_bank_array (
  input  wire logic                                   clk,
  input  wire xr_pkg::bank_mask_t                     porta_en,
  input  wire xr_pkg::row_t [xr_pkg::NUM_BANKS-1:0]   porta_row,
  input  wire logic                                   xor_porta_en,
  input  wire xr_pkg::row_t                           xor_porta_row,
  input  wire xr_pkg::bank_mask_t                     portb_en,
  input  wire logic                                   portb_we,
  input  wire xr_pkg::row_t                           portb_row,
  input  wire xr_pkg::data_t                          portb_wdata,
  input  wire logic                                   xor_portb_en,
  input  wire logic                                   xor_portb_we,
  input  wire xr_pkg::data_t                          xor_portb_wdata,
  output xr_pkg::data_t [xr_pkg::NUM_BANKS-1:0]       porta_dout,
  output xr_pkg::data_t                               xor_porta_dout,
  output xr_pkg::data_t [xr_pkg::NUM_BANKS-1:0]       portb_dout,
  output xr_pkg::data_t                               xor_portb_dout
);

  for (genvar b = 0; b < xr_pkg::NUM_BANKS; b++) begin : g_bank
    xr_dual_port_ram data_bank_inst (
      .clk     (clk),
      .a_en    (porta_en[b]),
      .a_row   (porta_row[b]),
      .a_dout  (porta_dout[b]),
      .b_en    (portb_en[b]),
      .b_we    (portb_we & portb_en[b]), // only the selected bank takes the write.
      .b_row   (portb_row),
      .b_wdata (portb_wdata),
      .b_dout  (portb_dout[b])
    );
  end

  // parity bank holding the xor of all data banks per row.
  xr_dual_port_ram xor_bank_inst (
    .clk     (clk),
    .a_en    (xor_porta_en),
    .a_row   (xor_porta_row),
    .a_dout  (xor_porta_dout),
    .b_en    (xor_portb_en),
    .b_we    (xor_portb_we & xor_portb_en),
    .b_row   (portb_row),
    .b_wdata (xor_portb_wdata),
    .b_dout  (xor_portb_dout)
  );

endmodule

`default_nettype wire

// File: design/xr_request_stage.sv
`timescale 1ns/1ps
`default_nettype none

module xr_request_stage (
  input  wire logic                                 clk,
  input  wire logic                                 reset,
  input  wire logic                                 ready,
  input  wire logic                                 write,
  input  wire xr_pkg::addr_t                        wr_adr,
  input  wire xr_pkg::data_t                        din,
  input  wire logic [1:0]                           read,
  input  wire xr_pkg::addr_t                        rd_adr0,
  input  wire xr_pkg::addr_t                        rd_adr1,
  output xr_pkg::bank_mask_t                        porta_en,
  output xr_pkg::row_t [xr_pkg::NUM_BANKS-1:0]      porta_row,
  output logic                                      xor_porta_en,
  output xr_pkg::row_t                              xor_porta_row,
  output logic [1:0]                                tag_vld,
  output xr_pkg::bank_t                             tag_bank0,
  output xr_pkg::bank_t                             tag_bank1,
  output logic                                      tag_rebuild,
  output logic                                      wr_vld,
  output xr_pkg::bank_t                             wr_bank,
  output xr_pkg::row_t                              wr_row,
  output xr_pkg::data_t                             wr_data
);

  xr_pkg::bank_t bank0;
  xr_pkg::bank_t bank1;
  xr_pkg::row_t  row0;
  xr_pkg::row_t  row1;
  logic          conflict;

  xr_pkg::bank_mask_t                   plan_en;
  xr_pkg::row_t [xr_pkg::NUM_BANKS-1:0] plan_row;
  logic                                 plan_xor_en;

  assign {bank0, row0} = rd_adr0;
  assign {bank1, row1} = rd_adr1;
  assign conflict = ready & read[0] & read[1] & (bank0 == bank1); // read 1 needs a rebuild.

  always_comb begin
    plan_en = '0;
    plan_row = '0;
    plan_xor_en = 1'b0;
    if (ready && read[0]) begin
      plan_en[bank0] = 1'b1;
      plan_row[bank0] = row0;
    end
    if (conflict) begin
      // every other bank plus the xor bank at read 1's row.
      for (int b = 0; b < xr_pkg::NUM_BANKS; b++) begin
        if (xr_pkg::bank_t'(b) != bank0) begin
          plan_en[b] = 1'b1;
          plan_row[b] = row1;
        end
      end
      plan_xor_en = 1'b1;
    end else if (ready && read[1]) begin
      plan_en[bank1] = 1'b1;
      plan_row[bank1] = row1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      porta_en <= '0;
      xor_porta_en <= 1'b0;
      tag_vld <= 2'b00;
      tag_rebuild <= 1'b0;
      wr_vld <= 1'b0;
    end else begin
      porta_en <= plan_en;
      xor_porta_en <= plan_xor_en;
      tag_vld <= read & {2{ready}}; // requests before ready are dropped.
      tag_rebuild <= conflict;
      wr_vld <= write & ready;
    end
  end

  always_ff @(posedge clk) begin
    porta_row <= plan_row;
    xor_porta_row <= row1;
    tag_bank0 <= bank0;
    tag_bank1 <= bank1;
    {wr_bank, wr_row} <= wr_adr;
    wr_data <= din;
  end

endmodule

`default_nettype wire

// File: design/xr_write_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module xr_write_sequencer (
  input  wire logic                                 clk,
  input  wire logic                                 reset,
  input  wire logic                                 wr_vld,
  input  wire xr_pkg::bank_t                        wr_bank,
  input  wire xr_pkg::row_t                         wr_row,
  input  wire xr_pkg::data_t                        wr_data,
  input  wire xr_pkg::data_t [xr_pkg::NUM_BANKS-1:0] portb_old,
  input  wire xr_pkg::data_t                        xor_portb_old,
  output logic                                      ready,
  output xr_pkg::bank_mask_t                        portb_en,
  output logic                                      portb_we,
  output xr_pkg::row_t                              portb_row,
  output xr_pkg::data_t                             portb_wdata,
  output logic                                      xor_portb_en,
  output logic                                      xor_portb_we,
  output xr_pkg::data_t                             xor_portb_wdata
);

  xr_pkg::write_state_t state;
  xr_pkg::row_t         init_row;

  logic          hold_vld;
  xr_pkg::bank_t hold_bank;
  xr_pkg::row_t  hold_row;
  xr_pkg::data_t hold_data;
  xr_pkg::data_t new_xor;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= xr_pkg::ws_init;
      init_row <= '0;
      hold_vld <= 1'b0;
    end else begin
      hold_vld <= wr_vld;
      case (state)
        xr_pkg::ws_init: begin
          init_row <= init_row + 1'b1;
          if (init_row == xr_pkg::row_t'(xr_pkg::NUM_ROWS - 1)) begin
            state <= xr_pkg::ws_idle; // last row cleared.
          end
        end
        xr_pkg::ws_idle: begin
          if (hold_vld) begin
            state <= xr_pkg::ws_update; // old words arrive next cycle.
          end
        end
        xr_pkg::ws_update: state <= xr_pkg::ws_idle;
        default: state <= xr_pkg::ws_init;
      endcase
    end
  end

  // writes come at least two cycles apart, so the hold is stable
  // through the following update.
  always_ff @(posedge clk) begin
    if (wr_vld) begin
      hold_bank <= wr_bank;
      hold_row <= wr_row;
      hold_data <= wr_data;
    end
  end

  assign new_xor = xor_portb_old ^ portb_old[hold_bank] ^ hold_data;
  assign ready = (state != xr_pkg::ws_init);

  always_comb begin
    portb_en = '0;
    portb_we = 1'b0;
    portb_row = hold_row;
    portb_wdata = hold_data;
    xor_portb_en = 1'b0;
    xor_portb_we = 1'b0;
    xor_portb_wdata = new_xor;
    case (state)
      xr_pkg::ws_init: begin
        portb_en = '1; // clear the row in every bank.
        portb_we = 1'b1;
        portb_row = init_row;
        portb_wdata = '0;
        xor_portb_en = 1'b1;
        xor_portb_we = 1'b1;
        xor_portb_wdata = '0;
      end
      xr_pkg::ws_idle: begin
        if (hold_vld) begin
          portb_en[hold_bank] = 1'b1; // fetch old word and old xor.
          xor_portb_en = 1'b1;
        end
      end
      xr_pkg::ws_update: begin
        portb_en[hold_bank] = 1'b1;
        portb_we = 1'b1;
        xor_portb_en = 1'b1;
        xor_portb_we = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: design/xr_read_merge.sv
`timescale 1ns/1ps
`default_nettype none

module xr_read_merge (
  input  wire logic                                 clk,
  input  wire logic                                 reset,
  input  wire logic [1:0]                           tag_vld,
  input  wire xr_pkg::bank_t                        tag_bank0,
  input  wire xr_pkg::bank_t                        tag_bank1,
  input  wire logic                                 tag_rebuild,
  input  wire xr_pkg::data_t [xr_pkg::NUM_BANKS-1:0] porta_dout,
  input  wire xr_pkg::data_t                        xor_porta_dout,
  output logic [1:0]                                rd_vld,
  output xr_pkg::data_t                             rd_dout0,
  output xr_pkg::data_t                             rd_dout1
);

  // tags one cycle later, aligned with the bank outputs.
  logic [1:0]    vld_d;
  xr_pkg::bank_t bank0_d;
  xr_pkg::bank_t bank1_d;
  logic          rebuild_d;
  xr_pkg::data_t rebuilt;

  always_ff @(posedge clk) begin
    if (reset) begin
      vld_d <= 2'b00;
    end else begin
      vld_d <= tag_vld;
    end
  end

  always_ff @(posedge clk) begin
    bank0_d <= tag_bank0;
    bank1_d <= tag_bank1;
    rebuild_d <= tag_rebuild;
  end

  always_comb begin
    rebuilt = xor_porta_dout;
    for (int b = 0; b < xr_pkg::NUM_BANKS; b++) begin
      if (xr_pkg::bank_t'(b) != bank0_d) begin
        rebuilt = rebuilt ^ porta_dout[b]; // bank0 holds read 0's row, skip it.
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_vld <= 2'b00;
    end else begin
      rd_vld <= vld_d;
    end
  end

  always_ff @(posedge clk) begin
    rd_dout0 <= porta_dout[bank0_d];
    rd_dout1 <= rebuild_d ? rebuilt : porta_dout[bank1_d];
  end

endmodule

`default_nettype wire

// File: design/xr_2r1w_top.sv
`timescale 1ns/1ps
`default_nettype none

module xr_2r1w_top (
  input  wire logic          clk,
  input  wire logic          reset,
  input  wire logic          write,
  input  wire xr_pkg::addr_t wr_adr,
  input  wire xr_pkg::data_t din,
  input  wire logic [1:0]    read,
  input  wire xr_pkg::addr_t rd_adr0,
  input  wire xr_pkg::addr_t rd_adr1,
  output logic               ready,
  output logic [1:0]         rd_vld,
  output xr_pkg::data_t      rd_dout0,
  output xr_pkg::data_t      rd_dout1
);

  xr_pkg::bank_mask_t                    porta_en;
  xr_pkg::row_t [xr_pkg::NUM_BANKS-1:0]  porta_row;
  logic                                  xor_porta_en;
  xr_pkg::row_t                          xor_porta_row;
  xr_pkg::data_t [xr_pkg::NUM_BANKS-1:0] porta_dout;
  xr_pkg::data_t                         xor_porta_dout;

  logic [1:0]    tag_vld;
  xr_pkg::bank_t tag_bank0;
  xr_pkg::bank_t tag_bank1;
  logic          tag_rebuild;

  logic          wr_vld;
  xr_pkg::bank_t wr_bank;
  xr_pkg::row_t  wr_row;
  xr_pkg::data_t wr_data;

  xr_pkg::bank_mask_t                    portb_en;
  logic                                  portb_we;
  xr_pkg::row_t                          portb_row;
  xr_pkg::data_t                         portb_wdata;
  logic                                  xor_portb_en;
  logic                                  xor_portb_we;
  xr_pkg::data_t                         xor_portb_wdata;
  xr_pkg::data_t [xr_pkg::NUM_BANKS-1:0] portb_dout;
  xr_pkg::data_t                         xor_portb_dout;

  xr_request_stage xr_request_stage_inst (
    .clk (clk), .reset (reset), .ready (ready),
    .write (write), .wr_adr (wr_adr), .din (din),
    .read (read), .rd_adr0 (rd_adr0), .rd_adr1 (rd_adr1),
    .porta_en (porta_en), .porta_row (porta_row),
    .xor_porta_en (xor_porta_en), .xor_porta_row (xor_porta_row),
    .tag_vld (tag_vld), .tag_bank0 (tag_bank0), .tag_bank1 (tag_bank1),
    .tag_rebuild (tag_rebuild),
    .wr_vld (wr_vld), .wr_bank (wr_bank), .wr_row (wr_row), .wr_data (wr_data)
  );

  xr_write_sequencer xr_write_sequencer_inst (
    .clk (clk), .reset (reset),
    .wr_vld (wr_vld), .wr_bank (wr_bank), .wr_row (wr_row), .wr_data (wr_data),
    .portb_old (portb_dout), .xor_portb_old (xor_portb_dout),
    .ready (ready),
    .portb_en (portb_en), .portb_we (portb_we), .portb_row (portb_row),
    .portb_wdata (portb_wdata),
    .xor_portb_en (xor_portb_en), .xor_portb_we (xor_portb_we),
    .xor_portb_wdata (xor_portb_wdata)
  );

  xr_bank_array xr_bank_array_inst (
    .clk (clk),
    .porta_en (porta_en), .porta_row (porta_row),
    .xor_porta_en (xor_porta_en), .xor_porta_row (xor_porta_row),
    .portb_en (portb_en), .portb_we (portb_we), .portb_row (portb_row),
    .portb_wdata (portb_wdata),
    .xor_portb_en (xor_portb_en), .xor_portb_we (xor_portb_we),
    .xor_portb_wdata (xor_portb_wdata),
    .porta_dout (porta_dout), .xor_porta_dout (xor_porta_dout),
    .portb_dout (portb_dout), .xor_portb_dout (xor_portb_dout)
  );

  xr_read_merge xr_read_merge_inst (
    .clk (clk), .reset (reset),
    .tag_vld (tag_vld), .tag_bank0 (tag_bank0), .tag_bank1 (tag_bank1),
    .tag_rebuild (tag_rebuild),
    .porta_dout (porta_dout), .xor_porta_dout (xor_porta_dout),
    .rd_vld (rd_vld), .rd_dout0 (rd_dout0), .rd_dout1 (rd_dout1)
  );

endmodule

`default_nettype wire

// File: tests/xr_2r1w_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module xr_2r1w_asserts (
  input wire logic       clk,
  input wire logic       reset,
  input wire logic       write,
  input wire logic       ready,
  input wire logic [1:0] rd_vld
);

  // a write holds port B for two cycles.
  write_spacing_a : assert property (
    @(posedge clk) disable iff (reset) write |=> !write
  ) else $error("write strobe high in two consecutive cycles");

  no_read_before_ready_a : assert property (
    @(posedge clk) disable iff (reset) !ready |-> (rd_vld == 2'b00)
  ) else $error("read valid while ready is low");

  ready_stays_high_a : assert property (
    @(posedge clk) disable iff (reset) ready |=> ready
  ) else $error("ready fell after the init sweep");

endmodule

`default_nettype wire

// File: tests/xr_2r1w_tb.sv
`timescale 1ns/1ps
`default_nettype none

module xr_2r1w_tb;

  localparam int CLK_PERIOD    = 100;
  localparam int RESET_CYCLES  = 4;
  localparam int RD_LATENCY    = 3;
  localparam int WR_VISIBLE    = 3;
  localparam int NUM_ADDR      = xr_pkg::NUM_BANKS * xr_pkg::NUM_ROWS;
  localparam int VIS_TESTS     = 16;
  localparam int RANDOM_CYCLES = 2000;
  localparam int TEST_CYCLES   = NUM_ADDR + 4 * VIS_TESTS + RANDOM_CYCLES + 2 * RD_LATENCY;
  localparam int LIMIT_CYCLES  = RESET_CYCLES + xr_pkg::NUM_ROWS + TEST_CYCLES + 100;

  // pending write (cyc, adr, d0) or predicted read result (cyc is the due cycle).
  typedef struct packed {
    logic [31:0]   cyc;
    logic [1:0]    vld;
    xr_pkg::addr_t adr;
    xr_pkg::data_t d0;
    xr_pkg::data_t d1;
  } entry_t;

  logic          clk;
  logic          reset;
  logic          write;
  logic          ready;
  logic [1:0]    read;
  logic [1:0]    rd_vld;
  xr_pkg::addr_t wr_adr;
  xr_pkg::addr_t rd_adr0;
  xr_pkg::addr_t rd_adr1;
  xr_pkg::data_t din;
  xr_pkg::data_t rd_dout0;
  xr_pkg::data_t rd_dout1;

  xr_pkg::data_t model_mem [NUM_ADDR];
  entry_t        write_q [$]; // writes not yet visible to reads.
  entry_t        result_q [$]; // one predicted result per cycle.
  int unsigned   cycle = 0;
  int            errors = 0;
  int            checks = 0;

  xr_2r1w_top xr_2r1w_top_inst (.*);

  bind xr_2r1w_top xr_2r1w_asserts xr_2r1w_asserts_inst (
    .clk (clk), .reset (reset), .write (write), .ready (ready), .rd_vld (rd_vld)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(LIMIT_CYCLES * CLK_PERIOD);
    $display("timeout: the run did not finish within %0d cycles", LIMIT_CYCLES);
    $display("TB FAILED");
    $finish;
  end

  task automatic check_value(input string name, input xr_pkg::data_t expected,
                             input xr_pkg::data_t actual);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("FAIL %s: expected 0x%h, got 0x%h in cycle %0d", name, expected, actual, cycle);
    end
  endtask

  // mostly rows 0..3, so reads often meet one bank and fresh writes.
  function automatic xr_pkg::addr_t pick_address();
    xr_pkg::row_t row;
    row = xr_pkg::row_t'($urandom_range(3, 0));
    if ($urandom_range(3, 0) == 0) begin
      row = xr_pkg::row_t'($urandom);
    end
    return {xr_pkg::bank_t'($urandom), row};
  endfunction

  task automatic apply_cycle(input logic wr_en, input xr_pkg::addr_t wa, input logic [1:0] rd_en,
                             input xr_pkg::addr_t a0, input xr_pkg::addr_t a1);
    entry_t ent;
    @(posedge clk);
    #1;
    cycle++;
    if (result_q.size() > 0 && result_q[0].cyc == cycle) begin
      ent = result_q.pop_front();
      check_value("rd_vld", xr_pkg::data_t'(ent.vld), xr_pkg::data_t'(rd_vld));
      if (ent.vld[0]) check_value("rd_dout0", ent.d0, rd_dout0);
      if (ent.vld[1]) check_value("rd_dout1", ent.d1, rd_dout1);
    end else begin
      check_value("rd_vld", '0, xr_pkg::data_t'(rd_vld));
    end
    write = wr_en;
    wr_adr = wa;
    din = xr_pkg::data_t'($urandom);
    read = rd_en;
    rd_adr0 = a0;
    rd_adr1 = a1;
    while (write_q.size() > 0 && write_q[0].cyc + WR_VISIBLE <= cycle) begin
      ent = write_q.pop_front();
      model_mem[ent.adr] = ent.d0; // old value until three cycles later.
    end
    ent = '{cyc: cycle, vld: 2'b00, adr: wa, d0: din, d1: '0};
    if (wr_en) write_q.push_back(ent);
    ent = '{cyc: cycle + RD_LATENCY, vld: rd_en, adr: a0, d0: model_mem[a0], d1: model_mem[a1]};
    result_q.push_back(ent);
  endtask

  task automatic check_reset_and_ready();
    repeat (RESET_CYCLES) begin
      @(posedge clk);
      #1;
      check_value("ready", '0, xr_pkg::data_t'(ready));
      check_value("rd_vld", '0, xr_pkg::data_t'(rd_vld));
    end
    reset = 1'b0;
    // the init sweep clears one row per cycle.
    for (int k = 1; k <= xr_pkg::NUM_ROWS; k++) begin
      @(posedge clk);
      #1;
      check_value("ready", xr_pkg::data_t'(k >= xr_pkg::NUM_ROWS), xr_pkg::data_t'(ready));
      check_value("rd_vld", '0, xr_pkg::data_t'(rd_vld));
      // reads while ready is low are dropped.
      read = (k < xr_pkg::NUM_ROWS) ? 2'b11 : 2'b00;
      rd_adr0 = pick_address();
      rd_adr1 = pick_address();
    end
  endtask

  initial begin
    xr_pkg::addr_t a0;
    xr_pkg::addr_t a1;
    logic          wr_en;
    void'($urandom(32'h2eb5));
    reset = 1'b1;
    write = 1'b0;
    wr_adr = '0;
    din = '0;
    read = 2'b00;
    rd_adr0 = '0;
    rd_adr1 = '0;
    model_mem = '{default: '0};
    check_reset_and_ready();
    // every word once, paired with another bank or with the same bank.
    for (int a = 0; a < NUM_ADDR; a++) begin
      a0 = xr_pkg::addr_t'(a);
      a1 = a0 ^ ((a % 2 == 0) ? xr_pkg::addr_t'(NUM_ADDR / 2) : xr_pkg::addr_t'(1));
      apply_cycle(1'b0, '0, 2'b11, a0, a1);
    end
    for (int i = 0; i < VIS_TESTS; i++) begin
      a0 = pick_address();
      a1 = a0 ^ xr_pkg::addr_t'(1); // same bank, neighbor row.
      apply_cycle(1'b1, a0, 2'b11, a0, a0);
      apply_cycle(1'b0, '0, 2'b11, a0, a1);
      apply_cycle(1'b0, '0, 2'b11, a1, a0);
      apply_cycle(1'b0, '0, 2'b11, a0, a0); // first cycle that sees the write.
    end
    wr_en = 1'b0;
    for (int i = 0; i < RANDOM_CYCLES; i++) begin
      a0 = pick_address();
      a1 = pick_address();
      if ($urandom_range(1, 0) == 0) begin
        a1 = {xr_pkg::bank_t'(a0 >> xr_pkg::ROW_BITS), xr_pkg::row_t'(a1)}; // bank conflict.
      end
      wr_en = !wr_en && ($urandom_range(2, 0) == 0); // never two writes back to back.
      apply_cycle(wr_en, pick_address(), 2'($urandom_range(3, 0)), a0, a1);
    end
    repeat (2 * RD_LATENCY) apply_cycle(1'b0, '0, 2'b00, '0, '0);
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: xr_2r1w.f
design/xr_pkg.sv
design/xr_dual_port_ram.sv
design/xr_bank_array.sv
design/xr_request_stage.sv
design/xr_write_sequencer.sv
design/xr_read_merge.sv
design/xr_2r1w_top.sv
tests/xr_2r1w_asserts.sv
tests/xr_2r1w_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the 2r1w memory testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module xr_2r1w_tb -f xr_2r1w.f

output=$(./obj_dir/Vxr_2r1w_tb) || true
echo "$output"

if echo "$output" | grep -qx "TB PASSED"; then
  exit 0
fi
exit 1
